// File: common/csr_defs.svh
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// CSR numbers
`define CSR_CRMD        14'h0
`define CSR_PRMD        14'h1
`define CSR_ECFG        14'h4
`define CSR_ESTAT       14'h5
`define CSR_ERA         14'h6
`define CSR_BADV        14'h7
`define CSR_EENTRY      14'hc
`define CSR_SAVE0       14'h30
`define CSR_SAVE1       14'h31
`define CSR_SAVE2       14'h32
`define CSR_SAVE3       14'h33
`define CSR_TID         14'h40
`define CSR_TCFG        14'h41
`define CSR_TVAL        14'h42
`define CSR_TICLR       14'h44

`define CRMD_PLV        1:0
`define CRMD_IE         2
`define CRMD_DA         3
`define CRMD_PG         4
`define CRMD_DATF       6:5
`define CRMD_DATM       8:7

`define PRMD_PPLV       1:0
`define PRMD_PIE        2

`define ECFG_LIE        12:0

`define ESTAT_IS_SOFT   1:0
`define ESTAT_IS_HARD   9:2
`define ESTAT_IS_TI     11
`define ESTAT_IS        12:0
`define ESTAT_ECODE     21:16
`define ESTAT_ESUBCODE  30:22

`define EENTRY_VA       31:6

`define TCFG_EN         0
`define TCFG_PERIODIC   1
`define TCFG_INITVAL    31:2

`define TICLR_CLR       0

// TLB refill exception code
`define ECODE_TLBR      6'h3f
`define SAVE_COUNT      4

`endif

// File: common/csr_pkg.sv
`default_nettype none

`include "csr_defs.svh"

package csr_pkg;

    // CSR number as seen on the read and write ports
    typedef logic [13:0] csr_addr_t;

    typedef logic [31:0] csr_word_t;

    typedef logic [5:0] ecode_t;

    // Bit 6 is the subcode flag, bits 5:0 the code
    typedef logic [6:0] exc_code_t;

    typedef logic [7:0] hw_irq_t;

    // Soft, hard, timer and IPI status bits
    typedef logic [12:0] irq_vec_t;

    typedef csr_word_t [`SAVE_COUNT-1:0] save_bank_t;

endpackage

`default_nettype wire

// File: trap/trap_csr.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defs.svh"

module trap_csr (
    input  wire                       clk,
    input  wire                       aresetn,
    input  wire                       wen,
    input  wire csr_pkg::csr_addr_t   waddr,
    input  wire csr_pkg::csr_word_t   wdata,
    input  wire                       exception,
    input  wire                       ertn,
    input  wire                       tlb_exception,
    input  wire csr_pkg::exc_code_t   exc_code,
    input  wire csr_pkg::csr_word_t   era_in,
    input  wire                       wen_badv,
    input  wire csr_pkg::csr_word_t   badv_in,
    output csr_pkg::csr_word_t        crmd,
    output csr_pkg::csr_word_t        prmd,
    output csr_pkg::csr_word_t        ecfg,
    output csr_pkg::csr_word_t        era,
    output csr_pkg::csr_word_t        badv,
    output csr_pkg::csr_word_t        eentry,
    output csr_pkg::save_bank_t       save,
    output logic [1:0]                is_soft,
    output csr_pkg::ecode_t           ecode,
    output logic [8:0]                esubcode
);
    import csr_pkg::*;

    logic       exception_d;
    logic       exc_take;

    logic [1:0] crmd_plv;
    logic       crmd_ie;
    logic       crmd_da;
    logic       crmd_pg;
    logic [1:0] crmd_datf;
    logic [1:0] crmd_datm;
    logic [1:0] prmd_pplv;
    logic       prmd_pie;
    irq_vec_t   ecfg_lie;
    logic [25:0] eentry_va;

    // Only the rising edge of a held exception level enters the handler
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            exception_d <= 1'b0;
        end else begin
            exception_d <= exception;
        end
    end

    assign exc_take = exception && !exception_d && !ertn;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            crmd_plv  <= 2'd0;
            crmd_ie   <= 1'b0;
            crmd_da   <= 1'b1;
            crmd_pg   <= 1'b0;
            crmd_datf <= 2'd1;
            crmd_datm <= 2'd1;
        end else if (ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
            // Back to paged mode after a refill
            if (ecode == `ECODE_TLBR) begin
                crmd_da <= 1'b0;
                crmd_pg <= 1'b1;
            end
        end else if (exc_take) begin
            crmd_plv <= 2'd0;
            crmd_ie  <= 1'b0;
            if (tlb_exception) begin
                crmd_da <= 1'b1;
                crmd_pg <= 1'b0;
            end
        end else if (wen && waddr == `CSR_CRMD) begin
            crmd_plv  <= wdata[`CRMD_PLV];
            crmd_ie   <= wdata[`CRMD_IE];
            crmd_datf <= wdata[`CRMD_DATF];
            crmd_datm <= wdata[`CRMD_DATM];
            // PG and DA only move as a legal pair
            if (wdata[`CRMD_PG] ^ wdata[`CRMD_DA]) begin
                crmd_pg <= wdata[`CRMD_PG];
                crmd_da <= wdata[`CRMD_DA];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            prmd_pplv <= 2'd0;
            prmd_pie  <= 1'b0;
        end else if (exc_take) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (wen && waddr == `CSR_PRMD) begin
            prmd_pplv <= wdata[`PRMD_PPLV];
            prmd_pie  <= wdata[`PRMD_PIE];
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            ecode    <= '0;
            esubcode <= '0;
        end else if (exc_take) begin
            ecode    <= exc_code[5:0];
            esubcode <= (exc_code[5:0] != 6'd0) ? {8'd0, exc_code[6]} : 9'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            era <= '0;
        end else if (exc_take) begin
            era <= era_in;
        end else if (wen && waddr == `CSR_ERA) begin
            era <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            badv <= '0;
        end else if (wen_badv) begin
            badv <= badv_in;
        end else if (wen && waddr == `CSR_BADV) begin
            badv <= wdata;
        end
    end

    // Plain software registers
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            ecfg_lie  <= '0;
            eentry_va <= '0;
            is_soft   <= 2'd0;
            save      <= '0;
        end else if (wen) begin
            if (waddr == `CSR_ECFG) begin
                ecfg_lie <= wdata[`ECFG_LIE];
            end
            if (waddr == `CSR_EENTRY) begin
                eentry_va <= wdata[`EENTRY_VA];
            end
            if (waddr == `CSR_ESTAT) begin
                is_soft <= wdata[`ESTAT_IS_SOFT];
            end
            for (int i = 0; i < `SAVE_COUNT; i++) begin
                if (waddr == csr_addr_t'(`CSR_SAVE0 + i)) begin
                    save[i] <= wdata;
                end
            end
        end
    end

    always_comb begin
        crmd              = '0;
        crmd[`CRMD_PLV]   = crmd_plv;
        crmd[`CRMD_IE]    = crmd_ie;
        crmd[`CRMD_DA]    = crmd_da;
        crmd[`CRMD_PG]    = crmd_pg;
        crmd[`CRMD_DATF]  = crmd_datf;
        crmd[`CRMD_DATM]  = crmd_datm;
        prmd              = '0;
        prmd[`PRMD_PPLV]  = prmd_pplv;
        prmd[`PRMD_PIE]   = prmd_pie;
        ecfg              = '0;
        ecfg[`ECFG_LIE]   = ecfg_lie;
        eentry            = '0;
        eentry[`EENTRY_VA] = eentry_va;
    end

endmodule

`default_nettype wire

// File: timer/timer_csr.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defs.svh"

module timer_csr (
    input  wire                       clk,
    input  wire                       aresetn,
    input  wire                       wen,
    input  wire csr_pkg::csr_addr_t   waddr,
    input  wire csr_pkg::csr_word_t   wdata,
    output csr_pkg::csr_word_t        tcfg,
    output csr_pkg::csr_word_t        tval,
    output csr_pkg::csr_word_t        tid,
    output logic                      timer_irq
);
    import csr_pkg::*;

    logic        tcfg_en;
    logic        tcfg_periodic;
    logic [29:0] tcfg_initval;
    logic        tcfg_wr;
    logic        ticlr_wr;
    logic        tval_dec;

    assign tcfg_wr  = wen && waddr == `CSR_TCFG;
    assign ticlr_wr = wen && waddr == `CSR_TICLR && wdata[`TICLR_CLR];
    assign tval_dec = !tcfg_wr && tcfg_en && tval != '0;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else if (tcfg_wr) begin
            tcfg_en       <= wdata[`TCFG_EN];
            tcfg_periodic <= wdata[`TCFG_PERIODIC];
            tcfg_initval  <= wdata[`TCFG_INITVAL];
        end
    end

    // Down-counter loaded by every TCFG write
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tval <= '0;
        end else if (tcfg_wr) begin
            tval <= {2'b00, wdata[`TCFG_INITVAL]};
        end else if (tval_dec) begin
            tval <= tval - 32'd1;
        end else if (tcfg_en && tcfg_periodic) begin
            tval <= {2'b00, tcfg_initval};
        end
    end

    // Clear beats a set on the same edge
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            timer_irq <= 1'b0;
        end else if (ticlr_wr) begin
            timer_irq <= 1'b0;
        end else if (tval_dec && tval == 32'd1) begin
            timer_irq <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tid <= '0;
        end else if (wen && waddr == `CSR_TID) begin
            tid <= wdata;
        end
    end

    always_comb begin
        tcfg                 = '0;
        tcfg[`TCFG_EN]       = tcfg_en;
        tcfg[`TCFG_PERIODIC] = tcfg_periodic;
        tcfg[`TCFG_INITVAL]  = tcfg_initval;
    end

endmodule

`default_nettype wire

// File: src/csr_read_irq.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defs.svh"

module csr_read_irq (
    input  wire csr_pkg::csr_addr_t   raddr,
    input  wire csr_pkg::csr_word_t   crmd,
    input  wire csr_pkg::csr_word_t   prmd,
    input  wire csr_pkg::csr_word_t   ecfg,
    input  wire csr_pkg::csr_word_t   era,
    input  wire csr_pkg::csr_word_t   badv,
    input  wire csr_pkg::csr_word_t   eentry,
    input  wire csr_pkg::save_bank_t  save,
    input  wire [1:0]                 is_soft,
    input  wire csr_pkg::ecode_t      ecode,
    input  wire [8:0]                 esubcode,
    input  wire csr_pkg::csr_word_t   tcfg,
    input  wire csr_pkg::csr_word_t   tval,
    input  wire csr_pkg::csr_word_t   tid,
    input  wire                       timer_irq,
    input  wire csr_pkg::hw_irq_t     hardware_interrupt,
    output csr_pkg::csr_word_t        rdata,
    output csr_pkg::csr_word_t        estat,
    output logic                      cpu_interrupt,
    output logic                      idle_over
);
    import csr_pkg::*;

    irq_vec_t is_vec;

    // Bits 10 and 12 have no source here
    always_comb begin
        is_vec                 = '0;
        is_vec[`ESTAT_IS_SOFT] = is_soft;
        is_vec[`ESTAT_IS_HARD] = hardware_interrupt;
        is_vec[`ESTAT_IS_TI]   = timer_irq;
    end

    always_comb begin
        estat                  = '0;
        estat[`ESTAT_IS]       = is_vec;
        estat[`ESTAT_ECODE]    = ecode;
        estat[`ESTAT_ESUBCODE] = esubcode;
    end

    always_comb begin
        case (raddr)
            `CSR_CRMD:   rdata = crmd;
            `CSR_PRMD:   rdata = prmd;
            `CSR_ECFG:   rdata = ecfg;
            `CSR_ESTAT:  rdata = estat;
            `CSR_ERA:    rdata = era;
            `CSR_BADV:   rdata = badv;
            `CSR_EENTRY: rdata = eentry;
            `CSR_SAVE0:  rdata = save[0];
            `CSR_SAVE1:  rdata = save[1];
            `CSR_SAVE2:  rdata = save[2];
            `CSR_SAVE3:  rdata = save[3];
            `CSR_TID:    rdata = tid;
            `CSR_TCFG:   rdata = tcfg;
            `CSR_TVAL:   rdata = tval;
            // Clear bit is write-only
            `CSR_TICLR:  rdata = '0;
            default:     rdata = '0;
        endcase
    end

    // Global enable plus any locally enabled pending line
    assign cpu_interrupt = crmd[`CRMD_IE] && |(ecfg[`ECFG_LIE] & is_vec);

    // Any pending line wakes the core, enabled or not
    assign idle_over = |is_vec;

endmodule

`default_nettype wire

// File: src/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit (
    input  wire                       clk,
    input  wire                       aresetn,
    input  wire                       wen,
    input  wire csr_pkg::csr_addr_t   waddr,
    input  wire csr_pkg::csr_word_t   wdata,
    input  wire csr_pkg::csr_addr_t   raddr,
    input  wire                       exception,
    input  wire                       ertn,
    input  wire                       tlb_exception,
    input  wire csr_pkg::exc_code_t   exc_code,
    input  wire csr_pkg::csr_word_t   era_in,
    input  wire                       wen_badv,
    input  wire csr_pkg::csr_word_t   badv_in,
    input  wire csr_pkg::hw_irq_t     hardware_interrupt,
    output csr_pkg::csr_word_t        rdata,
    output csr_pkg::csr_word_t        crmd,
    output csr_pkg::csr_word_t        estat,
    output csr_pkg::csr_word_t        era,
    output csr_pkg::csr_word_t        eentry,
    output logic                      cpu_interrupt,
    output logic                      idle_over
);
    import csr_pkg::*;

    csr_word_t  prmd;
    csr_word_t  ecfg;
    csr_word_t  badv;
    save_bank_t save;
    logic [1:0] is_soft;
    ecode_t     ecode;
    logic [8:0] esubcode;
    csr_word_t  tcfg;
    csr_word_t  tval;
    csr_word_t  tid;
    logic       timer_irq;

    trap_csr i_trap_csr (
        .clk, .aresetn, .wen, .waddr, .wdata,
        .exception, .ertn, .tlb_exception, .exc_code, .era_in,
        .wen_badv, .badv_in,
        .crmd, .prmd, .ecfg, .era, .badv, .eentry, .save,
        .is_soft, .ecode, .esubcode
    );

    timer_csr i_timer_csr (
        .clk, .aresetn, .wen, .waddr, .wdata,
        .tcfg, .tval, .tid, .timer_irq
    );

    // Read mux, ESTAT and interrupt outputs
    csr_read_irq i_csr_read_irq (
        .raddr, .crmd, .prmd, .ecfg, .era, .badv, .eentry, .save,
        .is_soft, .ecode, .esubcode, .tcfg, .tval, .tid, .timer_irq,
        .hardware_interrupt, .rdata, .estat, .cpu_interrupt, .idle_over
    );

endmodule

`default_nettype wire

// File: bench/csr_unit_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defs.svh"

module csr_unit_assert (
    input wire                       clk,
    input wire                       aresetn,
    input wire                       wen,
    input wire csr_pkg::csr_addr_t   waddr,
    input wire csr_pkg::csr_word_t   wdata,
    input wire csr_pkg::csr_word_t   crmd,
    input wire csr_pkg::csr_word_t   estat,
    input wire                       cpu_interrupt
);

    irq_needs_ie: assert property (@(posedge clk) disable iff (!aresetn)
        cpu_interrupt |-> crmd[`CRMD_IE])
        else $error("cpu_interrupt high while CRMD.IE is low");

    // Exactly one of direct and paged mode
    pg_da_pair: assert property (@(posedge clk) disable iff (!aresetn)
        crmd[`CRMD_PG] != crmd[`CRMD_DA])
        else $error("CRMD.PG and CRMD.DA are equal");

    ticlr_clears: assert property (@(posedge clk) disable iff (!aresetn)
        (wen && waddr == `CSR_TICLR && wdata[`TICLR_CLR]) |=> !estat[`ESTAT_IS_TI])
        else $error("timer status bit still set after a TICLR write");

endmodule

bind csr_unit csr_unit_assert i_csr_unit_assert (
    .clk, .aresetn, .wen, .waddr, .wdata, .crmd, .estat, .cpu_interrupt
);

`default_nettype wire

// File: bench/csr_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defs.svh"

module csr_unit_tb;
    import csr_pkg::*;

    localparam int timeout_cycles = 3000;

    logic       clk;
    logic       aresetn;
    logic       wen;
    csr_addr_t  waddr;
    csr_word_t  wdata;
    csr_addr_t  raddr;
    logic       exception;
    logic       ertn;
    logic       tlb_exception;
    exc_code_t  exc_code;
    csr_word_t  era_in;
    logic       wen_badv;
    csr_word_t  badv_in;
    hw_irq_t    hardware_interrupt;
    csr_word_t  rdata;
    csr_word_t  crmd;
    csr_word_t  estat;
    csr_word_t  era;
    csr_word_t  eentry;
    logic       cpu_interrupt;
    logic       idle_over;

    int         directed_errors;
    int         model_errors;
    int         cycle_count;
    int         edges;
    logic       check_on;
    logic [15:0] lfsr;
    string      test_name;
    csr_word_t  word;
    csr_addr_t  rw_addrs [8];

    // Shadow register state
    logic [1:0]  m_plv;
    logic        m_ie;
    logic        m_da;
    logic        m_pg;
    logic [1:0]  m_datf;
    logic [1:0]  m_datm;
    logic [1:0]  m_pplv;
    logic        m_pie;
    logic        m_exc_prev;
    logic [12:0] m_lie;
    logic [25:0] m_eentry;
    logic [1:0]  m_soft;
    logic [5:0]  m_ecode;
    logic [8:0]  m_esub;
    logic        m_en;
    logic        m_periodic;
    logic [29:0] m_init;
    logic        m_ti;
    csr_word_t   m_era;
    csr_word_t   m_badv;
    csr_word_t   m_tid;
    csr_word_t   m_tval;
    csr_word_t   m_save [4];

    csr_unit i_csr_unit (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the tests did not complete within %0d cycles", timeout_cycles);
        $display("Finished with errors");
        $finish;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_word(output csr_word_t w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_step(lfsr);
            w = {w[30:0], lfsr[0]};
        end
    endtask

    function automatic csr_word_t pack_crmd(input logic [1:0] plv, input logic ie,
                                            input logic da, input logic pg,
                                            input logic [1:0] datf, input logic [1:0] datm);
        return {23'd0, datm, datf, pg, da, ie, plv};
    endfunction

    function automatic csr_word_t writable_bits(input csr_addr_t addr);
        case (addr)
            `CSR_ECFG:   return 32'h0000_1fff;
            `CSR_EENTRY: return 32'hffff_ffc0;
            default:     return 32'hffff_ffff;
        endcase
    endfunction

    function automatic csr_word_t ref_crmd();
        return {23'd0, m_datm, m_datf, m_pg, m_da, m_ie, m_plv};
    endfunction

    function automatic irq_vec_t ref_status();
        return {1'b0, m_ti, 1'b0, hardware_interrupt, m_soft};
    endfunction

    function automatic csr_word_t ref_estat();
        return {1'b0, m_esub, m_ecode, 3'd0, ref_status()};
    endfunction

    function automatic csr_word_t ref_read(input csr_addr_t addr);
        case (addr)
            `CSR_CRMD:   return ref_crmd();
            `CSR_PRMD:   return {29'd0, m_pie, m_pplv};
            `CSR_ECFG:   return {19'd0, m_lie};
            `CSR_ESTAT:  return ref_estat();
            `CSR_ERA:    return m_era;
            `CSR_BADV:   return m_badv;
            `CSR_EENTRY: return {m_eentry, 6'd0};
            `CSR_SAVE0:  return m_save[0];
            `CSR_SAVE1:  return m_save[1];
            `CSR_SAVE2:  return m_save[2];
            `CSR_SAVE3:  return m_save[3];
            `CSR_TID:    return m_tid;
            `CSR_TCFG:   return {m_init, m_periodic, m_en};
            `CSR_TVAL:   return m_tval;
            default:     return 32'd0;
        endcase
    endfunction

    function automatic logic ref_cpu_int();
        return m_ie && |(m_lie & ref_status());
    endfunction

    // Shadow model stepped on every rising edge
    always @(posedge clk) begin : shadow_update
        logic       enter;
        logic       fire;
        logic [1:0] old_plv;
        logic       old_ie;
        if (!aresetn) begin
            m_plv = 2'd0;
            m_ie = 1'b0;
            m_da = 1'b1;
            m_pg = 1'b0;
            m_datf = 2'd1;
            m_datm = 2'd1;
            m_pplv = 2'd0;
            m_pie = 1'b0;
            m_exc_prev = 1'b0;
            m_lie = '0;
            m_eentry = '0;
            m_soft = '0;
            m_ecode = '0;
            m_esub = '0;
            m_en = 1'b0;
            m_periodic = 1'b0;
            m_init = '0;
            m_ti = 1'b0;
            m_era = '0;
            m_badv = '0;
            m_tid = '0;
            m_tval = '0;
            foreach (m_save[i]) m_save[i] = '0;
        end else begin
            enter = exception && !m_exc_prev && !ertn;
            fire = 1'b0;
            old_plv = m_plv;
            old_ie = m_ie;
            m_exc_prev = exception;
            if (ertn) begin
                m_plv = m_pplv;
                m_ie = m_pie;
                if (m_ecode == `ECODE_TLBR) begin
                    m_da = 1'b0;
                    m_pg = 1'b1;
                end
            end else if (enter) begin
                m_plv = 2'd0;
                m_ie = 1'b0;
                if (tlb_exception) begin
                    m_da = 1'b1;
                    m_pg = 1'b0;
                end
            end else if (wen && waddr == `CSR_CRMD) begin
                m_plv = wdata[`CRMD_PLV];
                m_ie = wdata[`CRMD_IE];
                m_datf = wdata[`CRMD_DATF];
                m_datm = wdata[`CRMD_DATM];
                if (wdata[`CRMD_PG] != wdata[`CRMD_DA]) begin
                    m_pg = wdata[`CRMD_PG];
                    m_da = wdata[`CRMD_DA];
                end
            end
            if (enter) begin
                m_pplv = old_plv;
                m_pie = old_ie;
                m_era = era_in;
                m_ecode = exc_code[5:0];
                m_esub = (exc_code[5:0] != 6'd0) ? {8'd0, exc_code[6]} : 9'd0;
            end else if (wen && waddr == `CSR_PRMD) begin
                m_pplv = wdata[`PRMD_PPLV];
                m_pie = wdata[`PRMD_PIE];
            end else if (wen && waddr == `CSR_ERA) begin
                m_era = wdata;
            end
            if (wen_badv) begin
                m_badv = badv_in;
            end else if (wen && waddr == `CSR_BADV) begin
                m_badv = wdata;
            end
            // Timer counts down to zero, then reloads only when periodic
            if (wen && waddr == `CSR_TCFG) begin
                m_en = wdata[`TCFG_EN];
                m_periodic = wdata[`TCFG_PERIODIC];
                m_init = wdata[`TCFG_INITVAL];
                m_tval = {2'b00, wdata[`TCFG_INITVAL]};
            end else if (m_en && m_tval != 32'd0) begin
                fire = (m_tval == 32'd1);
                m_tval = m_tval - 32'd1;
            end else if (m_en && m_periodic) begin
                m_tval = {2'b00, m_init};
            end
            if (wen && waddr == `CSR_TICLR && wdata[`TICLR_CLR]) begin
                m_ti = 1'b0;
            end else if (fire) begin
                m_ti = 1'b1;
            end
            if (wen) begin
                case (waddr)
                    `CSR_ECFG:   m_lie = wdata[`ECFG_LIE];
                    `CSR_EENTRY: m_eentry = wdata[`EENTRY_VA];
                    `CSR_ESTAT:  m_soft = wdata[`ESTAT_IS_SOFT];
                    `CSR_SAVE0:  m_save[0] = wdata;
                    `CSR_SAVE1:  m_save[1] = wdata;
                    `CSR_SAVE2:  m_save[2] = wdata;
                    `CSR_SAVE3:  m_save[3] = wdata;
                    `CSR_TID:    m_tid = wdata;
                    default: ;
                endcase
            end
        end
    end

    // Compares the DUT with the shadow model in the middle of each cycle
    always @(negedge clk) begin
        if (check_on) begin
            if (rdata !== ref_read(raddr)) begin
                model_errors++;
                $display("[FAIL] %s read %h: expected %h, actual %h",
                         test_name, raddr, ref_read(raddr), rdata);
            end
            if (estat !== ref_estat()) begin
                model_errors++;
                $display("[FAIL] %s estat: expected %h, actual %h",
                         test_name, ref_estat(), estat);
            end
            if (crmd !== ref_crmd()) begin
                model_errors++;
                $display("[FAIL] %s crmd: expected %h, actual %h", test_name, ref_crmd(), crmd);
            end
            if (era !== m_era || eentry !== {m_eentry, 6'd0}) begin
                model_errors++;
                $display("[FAIL] %s era/eentry: expected %h/%h, actual %h/%h",
                         test_name, m_era, {m_eentry, 6'd0}, era, eentry);
            end
            if ({cpu_interrupt, idle_over} !== {ref_cpu_int(), |ref_status()}) begin
                model_errors++;
                $display("[FAIL] %s irq outputs: expected %b%b, actual %b%b", test_name,
                         ref_cpu_int(), |ref_status(), cpu_interrupt, idle_over);
            end
        end
    end

    task automatic check_word(input string name, input csr_word_t expected,
                              input csr_word_t actual);
        if (actual !== expected) begin
            directed_errors++;
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, name, expected, actual);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic csr_write(input csr_addr_t addr, input csr_word_t data);
        wen = 1'b1;
        waddr = addr;
        wdata = data;
        step();
        wen = 1'b0;
    endtask

    task automatic expect_read(input string name, input csr_addr_t addr,
                               input csr_word_t expected);
        raddr = addr;
        #2;
        check_word(name, expected, rdata);
        step();
    endtask

    task automatic wait_timer_bit(input int limit);
        while (!estat[`ESTAT_IS_TI] && edges < limit) begin
            step();
            edges++;
        end
    endtask

    initial begin : stimulus
        aresetn = 1'b0;
        wen = 1'b0;
        waddr = '0;
        wdata = '0;
        raddr = '0;
        exception = 1'b0;
        ertn = 1'b0;
        tlb_exception = 1'b0;
        exc_code = '0;
        era_in = '0;
        wen_badv = 1'b0;
        badv_in = '0;
        hardware_interrupt = '0;
        check_on = 1'b0;
        directed_errors = 0;
        model_errors = 0;
        edges = 0;
        lfsr = 16'd62686;
        test_name = "reset";
        rw_addrs = '{`CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3,
                     `CSR_TID, `CSR_ERA, `CSR_ECFG, `CSR_EENTRY};
        repeat (5) @(posedge clk);
        #1;
        aresetn = 1'b1;
        check_on = 1'b1;

        expect_read("crmd reset", `CSR_CRMD, pack_crmd(2'd0, 1'b0, 1'b1, 1'b0, 2'd1, 2'd1));
        foreach (rw_addrs[i]) expect_read("zero after reset", rw_addrs[i], 32'd0);
        expect_read("prmd reset", `CSR_PRMD, 32'd0);
        expect_read("estat reset", `CSR_ESTAT, 32'd0);
        expect_read("tcfg reset", `CSR_TCFG, 32'd0);

        test_name = "readback";
        for (int r = 0; r < 3; r++) begin
            foreach (rw_addrs[i]) begin
                random_word(word);
                csr_write(rw_addrs[i], word);
                expect_read("random word", rw_addrs[i], word & writable_bits(rw_addrs[i]));
            end
        end
        expect_read("unmapped 0x2", 14'h2, 32'd0);
        expect_read("unmapped 0x43", 14'h43, 32'd0);
        expect_read("unmapped 0x3fff", 14'h3fff, 32'd0);

        test_name = "crmd write";
        csr_write(`CSR_CRMD, pack_crmd(2'd2, 1'b1, 1'b1, 1'b1, 2'd2, 2'd3));
        expect_read("pg=da=1", `CSR_CRMD, pack_crmd(2'd2, 1'b1, 1'b1, 1'b0, 2'd2, 2'd3));
        csr_write(`CSR_CRMD, pack_crmd(2'd1, 1'b0, 1'b0, 1'b0, 2'd3, 2'd2));
        expect_read("pg=da=0", `CSR_CRMD, pack_crmd(2'd1, 1'b0, 1'b1, 1'b0, 2'd3, 2'd2));
        csr_write(`CSR_CRMD, pack_crmd(2'd3, 1'b1, 1'b0, 1'b1, 2'd1, 2'd1));
        expect_read("paged", `CSR_CRMD, pack_crmd(2'd3, 1'b1, 1'b0, 1'b1, 2'd1, 2'd1));
        csr_write(`CSR_CRMD, pack_crmd(2'd0, 1'b0, 1'b1, 1'b1, 2'd1, 2'd1));
        expect_read("paged kept", `CSR_CRMD, pack_crmd(2'd0, 1'b0, 1'b0, 1'b1, 2'd1, 2'd1));
        csr_write(`CSR_CRMD, pack_crmd(2'd0, 1'b0, 1'b1, 1'b0, 2'd1, 2'd1));
        expect_read("direct", `CSR_CRMD, pack_crmd(2'd0, 1'b0, 1'b1, 1'b0, 2'd1, 2'd1));

        test_name = "exception";
        csr_write(`CSR_CRMD, pack_crmd(2'd3, 1'b1, 1'b1, 1'b0, 2'd1, 2'd1));
        random_word(word);
        era_in = word;
        exc_code = 7'h45;
        exception = 1'b1;
        step();
        // A held level must not enter again
        era_in = ~word;
        repeat (3) step();
        exception = 1'b0;
        expect_read("prmd", `CSR_PRMD, 32'h7);
        expect_read("crmd", `CSR_CRMD, pack_crmd(2'd0, 1'b0, 1'b1, 1'b0, 2'd1, 2'd1));
        expect_read("era", `CSR_ERA, word);
        expect_read("estat code", `CSR_ESTAT, {1'b0, 9'd1, 6'h05, 16'd0});
        ertn = 1'b1;
        step();
        ertn = 1'b0;
        expect_read("crmd after ertn", `CSR_CRMD,
                    pack_crmd(2'd3, 1'b1, 1'b1, 1'b0, 2'd1, 2'd1));

        test_name = "tlb refill";
        csr_write(`CSR_CRMD, pack_crmd(2'd0, 1'b1, 1'b0, 1'b1, 2'd1, 2'd1));
        exc_code = 7'h3f;
        tlb_exception = 1'b1;
        exception = 1'b1;
        step();
        exception = 1'b0;
        tlb_exception = 1'b0;
        expect_read("crmd", `CSR_CRMD, pack_crmd(2'd0, 1'b0, 1'b1, 1'b0, 2'd1, 2'd1));
        expect_read("prmd", `CSR_PRMD, 32'h4);
        expect_read("estat code", `CSR_ESTAT, {1'b0, 9'd0, 6'h3f, 16'd0});
        ertn = 1'b1;
        step();
        ertn = 1'b0;
        expect_read("crmd after ertn", `CSR_CRMD,
                    pack_crmd(2'd0, 1'b1, 1'b0, 1'b1, 2'd1, 2'd1));
        csr_write(`CSR_CRMD, pack_crmd(2'd0, 1'b0, 1'b1, 1'b0, 2'd1, 2'd1));

        test_name = "badv";
        random_word(word);
        wen_badv = 1'b1;
        badv_in = word;
        csr_write(`CSR_BADV, ~word);
        wen_badv = 1'b0;
        expect_read("capture beats write", `CSR_BADV, word);

        test_name = "timer one-shot";
        raddr = `CSR_TVAL;
        csr_write(`CSR_TCFG, {30'd10, 2'b01});
        edges = 0;
        wait_timer_bit(40);
        check_word("edges to timer bit", 32'd10, edges);
        repeat (3) step();
        check_word("timer bit held", 32'd1, {31'd0, estat[`ESTAT_IS_TI]});
        expect_read("tval stays 0", `CSR_TVAL, 32'd0);
        csr_write(`CSR_TICLR, 32'd1);
        check_word("timer bit cleared", 32'd0, {31'd0, estat[`ESTAT_IS_TI]});

        test_name = "timer periodic";
        raddr = `CSR_TVAL;
        csr_write(`CSR_TCFG, {30'd5, 2'b11});
        edges = 0;
        wait_timer_bit(40);
        check_word("edges to first set", 32'd5, edges);
        csr_write(`CSR_TICLR, 32'd1);
        edges = 1;
        check_word("cleared between periods", 32'd0, {31'd0, estat[`ESTAT_IS_TI]});
        wait_timer_bit(40);
        // One reload edge plus five decrements
        check_word("edges between sets", 32'd6, edges);
        csr_write(`CSR_TCFG, 32'd0);
        csr_write(`CSR_TICLR, 32'd1);

        test_name = "interrupts";
        for (int c = 0; c < 8; c++) begin
            csr_write(`CSR_CRMD, pack_crmd(2'd0, c[0], 1'b1, 1'b0, 2'd1, 2'd1));
            // Hardware line 3 is status bit 5
            csr_write(`CSR_ECFG, c[1] ? 32'h20 : 32'h1);
            hardware_interrupt = c[2] ? 8'h08 : 8'h00;
            #1;
            check_word("idle_over", {31'd0, c[2]}, {31'd0, idle_over});
            check_word("cpu_interrupt", {31'd0, c[0] & c[1] & c[2]}, {31'd0, cpu_interrupt});
        end
        hardware_interrupt = 8'h00;
        csr_write(`CSR_ESTAT, 32'h2);
        check_word("soft idle_over", 32'd1, {31'd0, idle_over});
        check_word("soft masked", 32'd0, {31'd0, cpu_interrupt});
        csr_write(`CSR_ECFG, 32'h2);
        check_word("soft enabled", 32'd1, {31'd0, cpu_interrupt});
        csr_write(`CSR_ESTAT, 32'h0);
        csr_write(`CSR_ECFG, 32'h800);
        csr_write(`CSR_TCFG, {30'd2, 2'b01});
        edges = 0;
        wait_timer_bit(20);
        check_word("timer idle_over", 32'd1, {31'd0, idle_over});
        check_word("timer enabled", 32'd1, {31'd0, cpu_interrupt});
        csr_write(`CSR_TICLR, 32'd1);
        check_word("timer cleared", 32'd0, {31'd0, idle_over});

        test_name = "end";
        repeat (2) step();
        $display("Directed errors: %0d, model errors: %0d", directed_errors, model_errors);
        if (directed_errors + model_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+common
common/csr_pkg.sv
trap/trap_csr.sv
timer/timer_csr.sv
src/csr_read_irq.sv
src/csr_unit.sv
bench/csr_unit_assert.sv
bench/csr_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the CSR unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module csr_unit_tb -o csr_unit_sim \
    || exit 1
./obj_dir/csr_unit_sim 2>&1 | tee /dev/stderr | grep -q "Finished with no errors" \
    && echo "PASS" || { echo "FAIL"; exit 1; }
